/* verilog/uartPkg.sv */
//////////////////////////////////////////////////
// uart peripheral shared definitions
//////////////////////////////////////////////////

package uartPkg;

	//////////////////////////////////////////////////
	// FSM state encodings

	// transmitter states
	typedef enum logic [1:0] {
		txIdle     = 2'b00,	// line held high
		txStartBit = 2'b01,	// line low for 16 ticks
		txDataBit  = 2'b10,	// data out lsb first
		txStopBit  = 2'b11		// line high for sbTick ticks
	} txState;

	// receiver states
	typedef enum logic [1:0] {
		rxIdle     = 2'b00,	// wait for falling edge
		rxStartBit = 2'b01,	// confirm start at mid-bit
		rxDataBit  = 2'b10,	// sample every 16 ticks
		rxStopBit  = 2'b11		// check stop at mid-bit
	} rxState;

	//////////////////////////////////////////////////
	// status byte bit positions
	localparam logic [2:0] statRxEmpty  = 3'd0;
	localparam logic [2:0] statRxFull   = 3'd1;
	localparam logic [2:0] statTxEmpty  = 3'd2;
	localparam logic [2:0] statTxFull   = 3'd3;
	localparam logic [2:0] statOverrun  = 3'd4;	// sticky
	localparam logic [2:0] statFrameErr = 3'd5;	// sticky

	// defaults for the top level parameters
	localparam int defDataBits      = 8;
	localparam int defSbTick        = 16;	// one stop bit
	localparam int defFifoAddrWidth = 4;	// 16 entries
	localparam int defBaudDivisor   = 54;	// clocks per 16x tick

endpackage

/* verilog/baudTickGen.sv */
//////////////////////////////////////////////////
// baud tick generator
//////////////////////////////////////////////////

`timescale 1ns/1ps

module baudTickGen #(
	parameter int baudDivisor = uartPkg::defBaudDivisor
) (
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	// at least one counter bit, even for a divide by one
	localparam int cntWidth = (baudDivisor > 1) ? $clog2(baudDivisor) : 1;

	logic [cntWidth-1:0] cntReg;
	logic                wrap;

	assign wrap = (cntReg == cntWidth'(baudDivisor - 1));	// last clock of period

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= '0;
			sTick  <= 1'b0;
		end
		else
		begin
			cntReg <= wrap ? '0 : cntReg + 1'b1;
			sTick  <= wrap;	// one clock wide
		end
	end

endmodule

/* verilog/uartTrans.sv */
//////////////////////////////////////////////////
// uart transmitter
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uartTrans #(
	parameter int dataBits = uartPkg::defDataBits,
	parameter int sbTick   = uartPkg::defSbTick
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                txStart,	// fifo not empty
	input  logic [dataBits-1:0] din,		// fifo head
	output logic                tx,
	output logic                txDoneTick	// fifo pop
);

	// tick counter must reach 15 and sbTick-1
	localparam int sWidth = (sbTick > 16) ? $clog2(sbTick) : 4;
	localparam int nWidth = (dataBits > 1) ? $clog2(dataBits) : 1;

	uartPkg::txState     stateReg, stateNext;
	logic [sWidth-1:0]   sReg, sNext;	// ticks within a bit
	logic [nWidth-1:0]   nReg, nNext;	// data bit index
	logic [dataBits-1:0] bReg, bNext;	// shift register
	logic                txReg, txNext;	// registered line

	//////////////////////////////////////////////////
	// state registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// idle high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;	// payload only
	end

	//////////////////////////////////////////////////
	// next state logic
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			uartPkg::txIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// pops fifo as the byte is taken
					bNext      = din;
					sNext      = '0;
					stateNext  = uartPkg::txStartBit;
				end
			end
			uartPkg::txStartBit:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == sWidth'(15))
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = uartPkg::txDataBit;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txDataBit:
			begin
				txNext = bReg[0];	// lsb first
				if (sTick)
				begin
					if (sReg == sWidth'(15))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == nWidth'(dataBits - 1))
							stateNext = uartPkg::txStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txStopBit:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == sWidth'(sbTick - 1))
						stateNext = uartPkg::txIdle;	// frame done
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::txIdle;
		endcase
	end

	assign tx = txReg;	// straight from a flop

endmodule

/* verilog/uartRecv.sv */
//////////////////////////////////////////////////
// uart oversampling receiver
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uartRecv #(
	parameter int dataBits = uartPkg::defDataBits,
	parameter int sbTick   = uartPkg::defSbTick
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                rx,
	output logic [dataBits-1:0] dout,
	output logic                rxDoneTick,	// fifo push
	output logic                frameErr		// stop sample low
);

	// ticks from last data sample to middle of stop bit, minus one
	localparam int stopMid = 7 + sbTick / 2;
	localparam int sWidth  = (stopMid > 15) ? $clog2(stopMid + 1) : 4;
	localparam int nWidth  = (dataBits > 1) ? $clog2(dataBits) : 1;

	uartPkg::rxState     stateReg, stateNext;
	logic [sWidth-1:0]   sReg, sNext;
	logic [nWidth-1:0]   nReg, nNext;
	logic [dataBits-1:0] bReg, bNext;
	logic [2:0]          rxSync;	// two sync flops plus previous value
	logic                rxIn;
	logic                rxFall;

	assign rxIn   = rxSync[1];
	assign rxFall = rxSync[2] & ~rxSync[1];

	//////////////////////////////////////////////////
	// synchronizer and state registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxSync   <= 3'b111;	// line idles high
			stateReg <= uartPkg::rxIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			rxSync   <= {rxSync[1:0], rx};
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////////////////////////
	// next state logic
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;
		frameErr   = 1'b0;
		case (stateReg)
			uartPkg::rxIdle:
				if (rxFall)
				begin
					sNext     = '0;
					stateNext = uartPkg::rxStartBit;
				end
			uartPkg::rxStartBit:
				if (sTick)
				begin
					if (sReg == sWidth'(7))	// middle of start bit
					begin
						sNext = '0;
						nNext = '0;
						// a high line here was only a glitch
						stateNext = rxIn ? uartPkg::rxIdle : uartPkg::rxDataBit;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxDataBit:
				if (sTick)
				begin
					if (sReg == sWidth'(15))
					begin
						sNext = '0;
						bNext = {rxIn, bReg[dataBits-1:1]};	// lsb arrives first
						if (nReg == nWidth'(dataBits - 1))
							stateNext = uartPkg::rxStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStopBit:
				if (sTick)
				begin
					if (sReg == sWidth'(stopMid))
					begin
						rxDoneTick = 1'b1;
						frameErr   = ~rxIn;	// byte kept anyway
						stateNext  = uartPkg::rxIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = uartPkg::rxIdle;
		endcase
	end

	assign dout = bReg;

endmodule

/* verilog/uartFifo.sv */
//////////////////////////////////////////////////
// first-word-fall-through FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uartFifo #(
	parameter int dataBits  = uartPkg::defDataBits,
	parameter int addrWidth = uartPkg::defFifoAddrWidth
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                push,
	input  logic                pop,
	input  logic [dataBits-1:0] wData,
	output logic [dataBits-1:0] rData,	// head, valid when not empty
	output logic                empty,
	output logic                full
);

	localparam int depth = 2 ** addrWidth;

	logic [dataBits-1:0] mem [depth];
	logic [addrWidth:0]  wPtr, rPtr;	// extra msb tells wrap
	logic                doPush, doPop;

	assign doPush = push & ~full;	// drop when full
	assign doPop  = pop & ~empty;	// ignore when empty

	//////////////////////////////////////////////////
	// flags from pointer compare
	assign empty = (wPtr == rPtr);
	assign full  = (wPtr[addrWidth] != rPtr[addrWidth]) &&
		(wPtr[addrWidth-1:0] == rPtr[addrWidth-1:0]);

	// pointers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wPtr <= '0;
			rPtr <= '0;
		end
		else
		begin
			if (doPush)
				wPtr <= wPtr + 1'b1;
			if (doPop)
				rPtr <= rPtr + 1'b1;	// head moves at the edge
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wPtr[addrWidth-1:0]] <= wData;
	end

	assign rData = mem[rPtr[addrWidth-1:0]];	// fall through

endmodule

/* verilog/uartPeripheral.sv */
//////////////////////////////////////////////////
// uart peripheral top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uartPeripheral #(
	parameter int dataBits      = uartPkg::defDataBits,
	parameter int sbTick        = uartPkg::defSbTick,
	parameter int fifoAddrWidth = uartPkg::defFifoAddrWidth,
	parameter int baudDivisor   = uartPkg::defBaudDivisor
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       wrStrobe,	// UARTwr
	input  logic [7:0] wrData,
	input  logic       rdStrobe,	// UARTrd
	input  logic       statusRead,	// UARTstat, clears sticky bits
	input  logic       rx,
	output logic [7:0] rdData,
	output logic [7:0] status,
	output logic       tx
);

	logic                sTick;
	logic [dataBits-1:0] txWData, txHead, rxWord, rxHead;
	logic                txEmpty, txFull, rxEmpty, rxFull;
	logic                txDoneTick, rxDoneTick, frameErr;
	logic                overrunReg, frameErrReg;

	assign txWData = dataBits'(wrData);
	assign rdData  = 8'(rxHead);

	//////////////////////////////////////////////////
	// datapath
	baudTickGen #(.baudDivisor(baudDivisor)) i_baudTickGen (
		.clk(clk), .reset(reset), .sTick(sTick)
	);

	uartFifo #(.dataBits(dataBits), .addrWidth(fifoAddrWidth)) txFifo (
		.clk(clk), .reset(reset), .push(wrStrobe), .pop(txDoneTick),
		.wData(txWData), .rData(txHead), .empty(txEmpty), .full(txFull)
	);

	uartTrans #(.dataBits(dataBits), .sbTick(sbTick)) i_uartTrans (
		.clk(clk), .reset(reset), .sTick(sTick), .txStart(~txEmpty),
		.din(txHead), .tx(tx), .txDoneTick(txDoneTick)
	);

	uartRecv #(.dataBits(dataBits), .sbTick(sbTick)) i_uartRecv (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.dout(rxWord), .rxDoneTick(rxDoneTick), .frameErr(frameErr)
	);

	uartFifo #(.dataBits(dataBits), .addrWidth(fifoAddrWidth)) rxFifo (
		.clk(clk), .reset(reset), .push(rxDoneTick & ~rxFull), .pop(rdStrobe),
		.wData(rxWord), .rData(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	//////////////////////////////////////////////////
	// sticky error bits, a new event beats the clear
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrunReg  <= 1'b0;
			frameErrReg <= 1'b0;
		end
		else
		begin
			if (statusRead)
			begin
				overrunReg  <= 1'b0;
				frameErrReg <= 1'b0;
			end
			if (rxDoneTick && rxFull)
				overrunReg <= 1'b1;	// byte lost
			if (frameErr)
				frameErrReg <= 1'b1;
		end
	end

	// live status byte
	always_comb
	begin
		status = 8'h00;
		status[uartPkg::statRxEmpty]  = rxEmpty;
		status[uartPkg::statRxFull]   = rxFull;
		status[uartPkg::statTxEmpty]  = txEmpty;
		status[uartPkg::statTxFull]   = txFull;
		status[uartPkg::statOverrun]  = overrunReg;
		status[uartPkg::statFrameErr] = frameErrReg;
	end

endmodule

/* tests/uartPeripheralTb.sv */
//////////////////////////////////////////////////
// uart peripheral testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module uartPeripheralTb;

	localparam int baudDiv   = 2;	// short frames
	localparam int stopTick  = 16;
	localparam int dataBits  = uartPkg::defDataBits;
	localparam int fifoDepth = 2 ** uartPkg::defFifoAddrWidth;
	localparam int bitClks   = 16 * baudDiv;	// clocks per serial bit
	localparam int frameClks = (16 * (1 + dataBits) + stopTick) * baudDiv;

	typedef enum logic [3:0] {
		opWrite, opWriteLost, opExpect, opStatus, opLine,
		opRaw, opStatRead, opLoopOff, opLoopOn, opSettle
	} stepOp;

	typedef struct packed {
		stepOp      op;
		logic [7:0] arg;	// data, expected status or line level
		logic       rnd;	// take the byte from the lfsr
	} stepEntry;

	logic            clk, reset, wrStrobe, rdStrobe, statusRead, tx;
	logic [7:0]      wrData, rdData, status;
	logic            rawLine, loopback, rxLine, tableReady;
	logic [15:0]     lfsrState;
	uartPkg::txState txFsm;
	stepEntry        steps[$];
	logic [7:0]      expectQ[$];	// bytes that should come back in order
	int              byteErrors, statusErrors, lineErrors, timeoutErrors;

	assign rxLine = loopback ? tx : rawLine;
	assign txFsm  = i_uartPeripheral.i_uartTrans.stateReg;	// peek at transmitter

	uartPeripheral #(.sbTick(stopTick), .baudDivisor(baudDiv)) i_uartPeripheral (
		.clk(clk), .reset(reset), .wrStrobe(wrStrobe), .wrData(wrData),
		.rdStrobe(rdStrobe), .statusRead(statusRead), .rx(rxLine),
		.rdData(rdData), .status(status), .tx(tx)
	);

	always #4 clk = ~clk;	// 8 ns period

	//////////////////////////////////////////////////
	// stimulus helpers
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] b;
		b = 8'h00;
		for (int i = 0; i < 8; i++)
			b = {b[6:0], lfsrBit()};	// one step per bit
		return b;
	endfunction

	// expected status built from the package bit positions
	function automatic logic [7:0] statByte(input logic rxE, rxF, txE, txF, ovr, fe);
		return (8'(rxE) << uartPkg::statRxEmpty) | (8'(rxF) << uartPkg::statRxFull) |
			(8'(txE) << uartPkg::statTxEmpty) | (8'(txF) << uartPkg::statTxFull) |
			(8'(ovr) << uartPkg::statOverrun) | (8'(fe) << uartPkg::statFrameErr);
	endfunction

	function automatic void addStep(input stepOp op, input logic [7:0] arg, input logic rnd);
		stepEntry e;
		e.op  = op;
		e.arg = arg;
		e.rnd = rnd;
		steps.push_back(e);
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	task automatic checkByte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			byteErrors++;
			$display("[ERROR] rdData: expected 0x%02h, got 0x%02h", exp, got);
		end
	endtask

	task automatic checkStatus(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			statusErrors++;
			$display("[ERROR] status: expected 0x%02h, got 0x%02h", exp, got);
		end
	endtask

	task automatic checkLine(input logic got, input logic exp);
		if (got !== exp)
		begin
			lineErrors++;
			$display("[ERROR] tx: expected 0x%01h, got 0x%01h", exp, got);
		end
	endtask

	//////////////////////////////////////////////////
	// step actions entered on a falling edge
	task automatic writeByte(input logic [7:0] b, input logic comesBack);
		wrData   = b;
		wrStrobe = 1'b1;
		@(negedge clk);
		wrStrobe = 1'b0;
		if (comesBack)
			expectQ.push_back(b);
	endtask

	task automatic expectByte();
		int waited;
		waited = 0;
		while (status[uartPkg::statRxEmpty] && waited < 2 * frameClks)
		begin
			@(negedge clk);
			waited++;
		end
		if (status[uartPkg::statRxEmpty])
		begin
			timeoutErrors++;
			$display("no received byte showed up within two frame times");
		end
		else if (expectQ.size() == 0)
		begin
			byteErrors++;
			$display("a byte arrived that the step table did not expect");
		end
		else
		begin
			checkByte(rdData, expectQ.pop_front());
			rdStrobe = 1'b1;	// pop the head
			@(negedge clk);
			rdStrobe = 1'b0;
		end
	endtask

	// hand-made frame with the stop bit held low
	task automatic rawFrame(input logic [7:0] b);
		rawLine = 1'b0;
		repeat (bitClks) @(negedge clk);
		for (int i = 0; i < dataBits; i++)
		begin
			rawLine = b[i];	// lsb first
			repeat (bitClks) @(negedge clk);
		end
		rawLine = 1'b0;	// bad stop bit
		repeat (bitClks) @(negedge clk);
		rawLine = 1'b1;
		repeat (bitClks) @(negedge clk);
		expectQ.push_back(b);	// delivered anyway
	endtask

	task automatic waitTx(input logic toIdle);
		int waited;
		waited = 0;
		// reconnect only while idle or stop bit holds the line high
		while (waited < (fifoDepth + 2) * frameClks &&
			!(toIdle ? (txFsm == uartPkg::txIdle && status[uartPkg::statTxEmpty]) :
			((txFsm == uartPkg::txIdle || txFsm == uartPkg::txStopBit) && tx)))
		begin
			@(negedge clk);
			waited++;
		end
		if (waited >= (fifoDepth + 2) * frameClks)
		begin
			timeoutErrors++;
			$display("transmitter never reached the expected state");
		end
		if (!toIdle)
			loopback = 1'b1;
	endtask

	task automatic runStep(input stepEntry s);
		case (s.op)
			opWrite:     writeByte(s.rnd ? randomByte() : s.arg, 1'b1);
			opWriteLost: writeByte(s.rnd ? randomByte() : s.arg, 1'b0);
			opExpect:    expectByte();
			opStatus:    checkStatus(status, s.arg);
			opLine:      checkLine(tx, s.arg[0]);
			opRaw:       rawFrame(s.arg);
			opStatRead:
			begin
				statusRead = 1'b1;
				@(negedge clk);
				statusRead = 1'b0;
			end
			opLoopOff:   loopback = 1'b0;
			opLoopOn:    waitTx(1'b0);
			opSettle:    waitTx(1'b1);
			default:
			begin
				timeoutErrors++;
				$display("step table holds an unknown operation");
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// step table
	task automatic buildTable();
		logic [7:0] idleStat;
		idleStat = statByte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		addStep(opStatus, idleStat, 1'b0);	// after reset
		addStep(opLine, 8'h01, 1'b0);
		addStep(opWrite, 8'hA5, 1'b0);	// single loopback byte
		addStep(opExpect, 8'h00, 1'b0);
		addStep(opStatus, idleStat, 1'b0);
		for (int i = 0; i < fifoDepth; i++)
			addStep(opWrite, 8'h00, 1'b1);	// burst
		for (int i = 0; i < fifoDepth; i++)
			addStep(opExpect, 8'h00, 1'b0);
		addStep(opSettle, 8'h00, 1'b0);
		addStep(opStatus, idleStat, 1'b0);
		addStep(opLoopOff, 8'h00, 1'b0);	// full and drop
		addStep(opWriteLost, 8'h00, 1'b1);	// sent onto the open line
		for (int i = 0; i < fifoDepth; i++)
			addStep(opWrite, 8'h00, 1'b1);
		addStep(opWriteLost, 8'h00, 1'b1);	// dropped by the full fifo
		addStep(opStatus, statByte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0), 1'b0);
		addStep(opLoopOn, 8'h00, 1'b0);
		for (int i = 0; i < fifoDepth; i++)
			addStep(opExpect, 8'h00, 1'b0);
		addStep(opSettle, 8'h00, 1'b0);
		addStep(opStatus, idleStat, 1'b0);
		for (int i = 0; i < fifoDepth; i++)
			addStep(opWrite, 8'h00, 1'b1);	// overrun
		addStep(opWriteLost, 8'h00, 1'b1);	// lost at the full rx fifo
		addStep(opSettle, 8'h00, 1'b0);
		addStep(opStatus, statByte(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0), 1'b0);
		for (int i = 0; i < fifoDepth; i++)
			addStep(opExpect, 8'h00, 1'b0);
		addStep(opStatus, statByte(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0), 1'b0);
		addStep(opStatRead, 8'h00, 1'b0);
		addStep(opStatus, idleStat, 1'b0);
		addStep(opLoopOff, 8'h00, 1'b0);	// framing error
		addStep(opRaw, 8'h3C, 1'b0);
		addStep(opExpect, 8'h00, 1'b0);
		addStep(opStatus, statByte(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1), 1'b0);
		addStep(opStatRead, 8'h00, 1'b0);
		addStep(opStatus, idleStat, 1'b0);
		addStep(opLoopOn, 8'h00, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	initial
	begin
		clk        = 1'b0;
		reset      = 1'b1;
		wrStrobe   = 1'b0;
		wrData     = 8'h00;
		rdStrobe   = 1'b0;
		statusRead = 1'b0;
		rawLine    = 1'b1;	// idle high
		loopback   = 1'b1;
		tableReady = 1'b0;
		lfsrState  = 16'd42;	// seed
		byteErrors    = 0;
		statusErrors  = 0;
		lineErrors    = 0;
		timeoutErrors = 0;
		buildTable();
		tableReady = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		foreach (steps[i])
			runStep(steps[i]);
		$display("errors: byte %0d, status %0d, line %0d, timeout %0d",
			byteErrors, statusErrors, lineErrors, timeoutErrors);
		if (byteErrors + statusErrors + lineErrors + timeoutErrors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// watchdog over steps x two frames x 1.5
	initial
	begin
		wait (tableReady);
		repeat (steps.size() * 2 * frameClks * 3 / 2) @(posedge clk);
		$display("watchdog expired before the step table finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* list.f */
verilog/uartPkg.sv
verilog/baudTickGen.sv
verilog/uartTrans.sv
verilog/uartRecv.sv
verilog/uartFifo.sv
verilog/uartPeripheral.sv
tests/uartPeripheralTb.sv

/* run.sh */
#!/bin/sh
# build and run the uart peripheral testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module uartPeripheralTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "run ok"
	exit 0
else
	echo "run failed, see sim.log"
	exit 1
fi
